/* run.sh */
#!/usr/bin/env bash
# Build and run the trace unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f rvfi_trace_top.f \
  --top-module tb_rvfi_trace_top -o tb_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
grep -q '^>>> PASS$' sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* rvc_expander.sv */
/*
  RV32C expander
  Turns the supported compressed instructions into their 32-bit
  equivalents. Full-width instructions pass through, any other
  compressed encoding becomes the all-zero illegal word.
*/
`timescale 1ns/100ps

module rvc_expander
  import rvfi_trace_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o
);

  logic [15:0] c;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rd_prime;
  logic [4:0]  rs1_prime;

  assign c         = instr_i[15:0];
  assign rd_full   = c[11:7];
  assign rs2_full  = c[6:2];
  // Compressed registers x8..x15
  assign rd_prime  = {2'b01, c[4:2]};
  assign rs1_prime = {2'b01, c[9:7]};

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o = '0;
    if (instr_i[1:0] == 2'b11) begin
      instr_o = instr_i;
    end else begin
      unique case ({c[1:0], c[15:13]})
        // C.LW
        {2'b00, 3'b010}: begin
          instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_prime, 3'b010,
                     rd_prime, OPC_LOAD};
        end
        // C.SW, rs2' sits where rd' would be
        {2'b00, 3'b110}: begin
          instr_o = {5'b0, c[5], c[12], rd_prime, rs1_prime, 3'b010,
                     c[11:10], c[6], 2'b00, OPC_STORE};
        end
        // C.ADDI
        {2'b01, 3'b000}: begin
          instr_o = {{6{c[12]}}, c[12], c[6:2], rd_full, 3'b000, rd_full, OPC_OP_IMM};
        end
        // C.LI
        {2'b01, 3'b010}: begin
          instr_o = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, rd_full, OPC_OP_IMM};
        end
        {2'b01, 3'b011}: begin
          // rd of x2 is C.ADDI16SP, not in the subset
          if (rd_full != 5'd2) begin
            instr_o = {{14{c[12]}}, c[12], c[6:2], rd_full, OPC_LUI};
          end
        end
        // C.J as jal x0
        {2'b01, 3'b101}: begin
          instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                     c[12], {8{c[12]}}, 5'b0, OPC_JAL};
        end
        // C.BEQZ as beq rs1', x0
        {2'b01, 3'b110}: begin
          instr_o = {c[12], {3{c[12]}}, c[6:5], c[2], 5'b0, rs1_prime, 3'b000,
                     c[11:10], c[4:3], c[12], OPC_BRANCH};
        end
        {2'b10, 3'b100}: begin
          // A zero rs2 encodes the jump and ebreak forms
          if (rs2_full != 5'd0) begin
            if (c[12] == 1'b0) begin
              // C.MV as add rd, x0, rs2
              instr_o = {7'b0, rs2_full, 5'b0, 3'b000, rd_full, OPC_OP};
            end else begin
              // C.ADD as add rd, rd, rs2
              instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
            end
          end
        end
        default: begin
          instr_o = '0;
        end
      endcase
    end
  end

endmodule

/* rvfi_trace_capture.sv */
/*
  Per-hart retirement capture
  Stamps each retirement with the cycle count, expands compressed code,
  picks operand registers, decodes the immediate and classifies the memory
  access. Records wait in a two-entry queue, overflow sets a drop flag.
*/
`timescale 1ns/100ps

module rvfi_trace_capture
  import rvfi_trace_pkg::*;
#(
  parameter int FPU = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  rvfi_t      rvfi_i,
  input  logic       gnt_i,
  output logic       req_o,
  output trace_rec_t rec_o
);

  logic [31:0] cycle_q;
  logic [31:0] insn_exp;
  logic        insn_compressed;
  imm_fmt_e    imm_fmt;
  logic [31:0] imm;
  trace_rec_t  rec_new;

  trace_rec_t  queue_q [2];
  logic [1:0]  count_q;
  logic        drop_q;
  logic        push;
  logic        pop;
  logic        wr_slot;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 32'd1;
    end
  end

  rvc_expander rvc_expander_i (
    .instr_i         (rvfi_i.insn),
    .instr_o         (insn_exp),
    .is_compressed_o (insn_compressed)
  );

  // Immediate format follows the expanded opcode
  always_comb begin
    unique case (insn_exp[6:0])
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: imm_fmt = IMM_I;
      OPC_STORE:                      imm_fmt = IMM_S;
      OPC_BRANCH:                     imm_fmt = IMM_B;
      OPC_LUI, OPC_AUIPC:             imm_fmt = IMM_U;
      OPC_JAL:                        imm_fmt = IMM_J;
      default:                        imm_fmt = IMM_NONE;
    endcase
  end

  always_comb begin
    unique case (imm_fmt)
      IMM_I:   imm = {{20{insn_exp[31]}}, insn_exp[31:20]};
      IMM_S:   imm = {{20{insn_exp[31]}}, insn_exp[31:25], insn_exp[11:7]};
      IMM_B:   imm = {{19{insn_exp[31]}}, insn_exp[31], insn_exp[7],
                      insn_exp[30:25], insn_exp[11:8], 1'b0};
      IMM_U:   imm = {insn_exp[31:12], 12'b0};
      IMM_J:   imm = {{11{insn_exp[31]}}, insn_exp[31], insn_exp[19:12],
                      insn_exp[20], insn_exp[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    rec_new            = '0;
    rec_new.dropped    = drop_q;
    rec_new.cycle      = cycle_q;
    rec_new.pc         = rvfi_i.pc;
    rec_new.insn       = insn_exp;
    rec_new.compressed = insn_compressed;
    rec_new.rd_wdata   = rvfi_i.rd_wdata;
    rec_new.imm        = imm;
    rec_new.mem_addr   = rvfi_i.mem_addr;

    // FP operands only exist with an FPU
    if (FPU != 0 && rvfi_i.frs1_rvalid) begin
      rec_new.rs1       = {1'b1, rvfi_i.frs1_addr};
      rec_new.rs1_value = rvfi_i.frs1_rdata;
    end else begin
      rec_new.rs1       = {1'b0, rvfi_i.rs1_addr};
      rec_new.rs1_value = rvfi_i.rs1_rdata;
    end
    if (FPU != 0 && rvfi_i.frs2_rvalid) begin
      rec_new.rs2       = {1'b1, rvfi_i.frs2_addr};
      rec_new.rs2_value = rvfi_i.frs2_rdata;
    end else begin
      rec_new.rs2       = {1'b0, rvfi_i.rs2_addr};
      rec_new.rs2_value = rvfi_i.rs2_rdata;
    end
    if (FPU != 0 && rvfi_i.frd_wvalid) begin
      rec_new.rd = {1'b1, rvfi_i.frd_addr};
    end else begin
      rec_new.rd = {1'b0, rvfi_i.rd_addr};
    end

    // A store wins over a load when both masks are set
    if (|rvfi_i.mem_wmask) begin
      rec_new.mem_kind = MEM_WRITE;
      rec_new.mem_data = rvfi_i.mem_wdata;
    end else if (|rvfi_i.mem_rmask) begin
      rec_new.mem_kind = MEM_READ;
      rec_new.mem_data = rvfi_i.mem_rdata;
    end else begin
      rec_new.mem_kind = MEM_NONE;
      rec_new.mem_data = '0;
    end
  end

  // Full queue still accepts when the head leaves this cycle
  assign pop  = gnt_i;
  assign push = rvfi_i.valid && (count_q != 2'd2 || pop);

  // Slot behind the surviving entries
  assign wr_slot = pop ? (count_q == 2'd2) : (count_q == 2'd1);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      drop_q  <= 1'b0;
    end else begin
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
      if (push) begin
        drop_q <= 1'b0;
      end else if (rvfi_i.valid) begin
        drop_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      queue_q[0] <= queue_q[1];
    end
    if (push) begin
      queue_q[wr_slot] <= rec_new;
    end
  end

  assign req_o = (count_q != 2'd0);
  assign rec_o = queue_q[0];

  // Never more than the two entries the queue holds
  assert property (@(posedge clk_i) disable iff (!rst_ni) count_q <= 2'd2);

  // The arbiter may only take a head that exists
  assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i |-> req_o);

endmodule

/* rvfi_trace_pkg.sv */
/*
  RVFI trace package
  Shared types for the two-hart retirement trace unit. Holds the RVFI
  retirement port, the trace record, the register id, the memory and
  immediate classifications and the base opcodes.
*/
package rvfi_trace_pkg;

  // Register id, top bit marks a floating-point register
  typedef logic [5:0] reg_id_t;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_kind_e;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_e;

  // Major opcodes, insn[6:0]
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // One retirement as presented by a hart
  typedef struct packed {
    logic        valid;
    logic [31:0] insn;
    logic [31:0] pc;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        frd_wvalid;
    logic [4:0]  frd_addr;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_rdata;
    logic [31:0] rs2_rdata;
    logic        frs1_rvalid;
    logic        frs2_rvalid;
    logic [4:0]  frs1_addr;
    logic [4:0]  frs2_addr;
    logic [31:0] frs1_rdata;
    logic [31:0] frs2_rdata;
    logic [31:0] mem_addr;
    logic [3:0]  mem_rmask;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
  } rvfi_t;

  // One trace record towards the sink
  typedef struct packed {
    logic        hart;
    logic        dropped;
    logic [31:0] cycle;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        compressed;
    reg_id_t     rd;
    reg_id_t     rs1;
    reg_id_t     rs2;
    logic [31:0] rd_wdata;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] imm;
    mem_kind_e   mem_kind;
    logic [31:0] mem_addr;
    logic [31:0] mem_data;
  } trace_rec_t;

endpackage

/* rvfi_trace_top.f */
rvfi_trace_pkg.sv
rvc_expander.sv
rvfi_trace_capture.sv
trace_arbiter.sv
trace_buffer.sv
rvfi_trace_top.sv
tb_rvfi_trace_top.sv

/* rvfi_trace_top.sv */
/*
  Two-hart retirement trace unit
  One capture unit per hart, a round-robin arbiter and a shared
  credit-controlled buffer towards the trace sink.
*/
`timescale 1ns/100ps

module rvfi_trace_top
  import rvfi_trace_pkg::*;
#(
  parameter int FPU          = 0,
  parameter int DEPTH        = 8,
  parameter int SINK_CREDITS = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  rvfi_t      rvfi0_i,
  input  rvfi_t      rvfi1_i,
  input  logic       credit_i,
  output logic       trace_valid_o,
  output trace_rec_t trace_rec_o
);

  localparam int NUM_PORTS = 2;

  logic [NUM_PORTS-1:0] cap_req;
  logic [NUM_PORTS-1:0] cap_gnt;
  trace_rec_t           cap_rec [NUM_PORTS];
  logic                 buf_push;
  logic                 buf_ready;
  trace_rec_t           buf_rec;

  rvfi_trace_capture #(
    .FPU (FPU)
  ) rvfi_trace_capture0_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rvfi_i (rvfi0_i),
    .gnt_i  (cap_gnt[0]),
    .req_o  (cap_req[0]),
    .rec_o  (cap_rec[0])
  );

  rvfi_trace_capture #(
    .FPU (FPU)
  ) rvfi_trace_capture1_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rvfi_i (rvfi1_i),
    .gnt_i  (cap_gnt[1]),
    .req_o  (cap_req[1]),
    .rec_o  (cap_rec[1])
  );

  trace_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) trace_arbiter_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (cap_req),
    .rec_i   (cap_rec),
    .ready_i (buf_ready),
    .gnt_o   (cap_gnt),
    .push_o  (buf_push),
    .rec_o   (buf_rec)
  );

  trace_buffer #(
    .DEPTH        (DEPTH),
    .SINK_CREDITS (SINK_CREDITS)
  ) trace_buffer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (buf_push),
    .rec_i         (buf_rec),
    .ready_o       (buf_ready),
    .credit_i      (credit_i),
    .trace_valid_o (trace_valid_o),
    .trace_rec_o   (trace_rec_o)
  );

endmodule

/* tb_rvfi_trace_top.sv */
/*
  Testbench for the two-hart retirement trace unit
  Directed tests drive both RVFI ports, a model queue per hart holds the
  expected records and a sink model checks every record and returns credit.
*/
`timescale 1ns/100ps

module tb_rvfi_trace_top
  import rvfi_trace_pkg::*;
;

  localparam int SINK_CREDITS = 4;
  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk_i;
  logic       rst_ni;
  rvfi_t      rvfi0_i;
  rvfi_t      rvfi1_i;
  logic       credit_i;
  logic       trace_valid_o;
  trace_rec_t trace_rec_o;

  trace_rec_t  exp_q [2][$];
  logic [31:0] cyc;
  logic [31:0] next_pc;
  int          owed;
  int          ticks;
  int          sent_in_hold;
  bit          hold;
  bit          subseq_mode;
  bit          gap_seen;

  rvfi_trace_top #(
    .FPU          (1),
    .DEPTH        (8),
    .SINK_CREDITS (SINK_CREDITS)
  ) rvfi_trace_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi0_i       (rvfi0_i),
    .rvfi1_i       (rvfi1_i),
    .credit_i      (credit_i),
    .trace_valid_o (trace_valid_o),
    .trace_rec_o   (trace_rec_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Mirror of the free-running retirement cycle count
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 32'd1;
    end
  end

  always @(posedge clk_i) begin
    ticks++;
    if (ticks > TIMEOUT_CYCLES) begin
      $display("Timeout: the trace unit stopped delivering records");
      $display(">>> FAIL");
      $fatal(1, "run aborted");
    end
  end

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("MISMATCH %s got %h expected %h", name, got, exp);
    $display(">>> FAIL");
    $fatal(1, "record check failed");
  endtask

  task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic check_kind(mem_kind_e got, mem_kind_e exp);
    if (got !== exp) begin
      report_mismatch("mem_kind", 32'(got), 32'(exp));
    end
  endtask

  task automatic check_rec(trace_rec_t got, trace_rec_t exp);
    compare_field("hart", 32'(got.hart), 32'(exp.hart));
    compare_field("dropped", 32'(got.dropped), 32'(exp.dropped));
    compare_field("cycle", got.cycle, exp.cycle);
    compare_field("pc", got.pc, exp.pc);
    compare_field("insn", got.insn, exp.insn);
    compare_field("compressed", 32'(got.compressed), 32'(exp.compressed));
    compare_field("rd", 32'(got.rd), 32'(exp.rd));
    compare_field("rs1", 32'(got.rs1), 32'(exp.rs1));
    compare_field("rs2", 32'(got.rs2), 32'(exp.rs2));
    compare_field("rd_wdata", got.rd_wdata, exp.rd_wdata);
    compare_field("rs1_value", got.rs1_value, exp.rs1_value);
    compare_field("rs2_value", got.rs2_value, exp.rs2_value);
    compare_field("imm", got.imm, exp.imm);
    check_kind(got.mem_kind, exp.mem_kind);
    compare_field("mem_addr", got.mem_addr, exp.mem_addr);
    compare_field("mem_data", got.mem_data, exp.mem_data);
  endtask

  // Sink model, records are stable at the falling edge
  always @(negedge clk_i) begin
    trace_rec_t got;
    trace_rec_t exp;
    bit         skipped;
    if (rst_ni && trace_valid_o) begin
      got     = trace_rec_o;
      skipped = 1'b0;
      if (subseq_mode) begin
        while (exp_q[got.hart].size() > 0 && exp_q[got.hart][0].pc != got.pc) begin
          void'(exp_q[got.hart].pop_front());
          skipped = 1'b1;
        end
      end
      if (exp_q[got.hart].size() == 0) begin
        $display("Record with pc %h arrived that was never retired", got.pc);
        $display(">>> FAIL");
        $fatal(1, "unexpected record");
      end
      exp = exp_q[got.hart].pop_front();
      if (subseq_mode) begin
        exp.dropped = skipped;
        gap_seen = gap_seen | skipped;
      end
      check_rec(got, exp);
      owed++;
      if (hold) begin
        sent_in_hold++;
      end
    end
  end

  // One credit back per cycle, one cycle after each record
  always @(posedge clk_i) begin
    #10;
    if (!hold && owed > 0) begin
      credit_i = 1'b1;
      owed--;
    end else begin
      credit_i = 1'b0;
    end
  end

  function automatic rvfi_t random_port();
    rvfi_t r;
    r           = '0;
    r.rd_addr   = 5'($urandom);
    r.rd_wdata  = $urandom;
    r.frd_addr  = 5'($urandom);
    r.rs1_addr  = 5'($urandom);
    r.rs2_addr  = 5'($urandom);
    r.rs1_rdata = $urandom;
    r.rs2_rdata = $urandom;
    r.frs1_addr = 5'($urandom);
    r.frs2_addr = 5'($urandom);
    r.frs1_rdata = $urandom;
    r.frs2_rdata = $urandom;
    r.mem_addr  = $urandom;
    r.mem_rdata = $urandom;
    r.mem_wdata = $urandom;
    return r;
  endfunction

  function automatic trace_rec_t build_expected(bit h, rvfi_t r, logic [31:0] insn,
                                                logic [31:0] imm, bit comp);
    trace_rec_t e;
    e            = '0;
    e.hart       = h;
    e.cycle      = cyc;
    e.pc         = r.pc;
    e.insn       = insn;
    e.compressed = comp;
    e.imm        = imm;
    e.rd_wdata   = r.rd_wdata;
    e.mem_addr   = r.mem_addr;
    e.rd         = r.frd_wvalid ? {1'b1, r.frd_addr} : {1'b0, r.rd_addr};
    e.rs1        = r.frs1_rvalid ? {1'b1, r.frs1_addr} : {1'b0, r.rs1_addr};
    e.rs2        = r.frs2_rvalid ? {1'b1, r.frs2_addr} : {1'b0, r.rs2_addr};
    e.rs1_value  = r.frs1_rvalid ? r.frs1_rdata : r.rs1_rdata;
    e.rs2_value  = r.frs2_rvalid ? r.frs2_rdata : r.rs2_rdata;
    if (r.mem_wmask != 0) begin
      e.mem_kind = MEM_WRITE;
      e.mem_data = r.mem_wdata;
    end else if (r.mem_rmask != 0) begin
      e.mem_kind = MEM_READ;
      e.mem_data = r.mem_rdata;
    end else begin
      e.mem_kind = MEM_NONE;
    end
    return e;
  endfunction

  // Presents one retirement for the coming edge
  task automatic drive_retire(bit h, rvfi_t r, logic [31:0] raw, logic [31:0] insn,
                              logic [31:0] imm, bit comp);
    r.valid = 1'b1;
    r.insn  = raw;
    r.pc    = next_pc;
    next_pc = next_pc + 32'd4;
    exp_q[h].push_back(build_expected(h, r, insn, imm, comp));
    if (h) begin
      rvfi1_i = r;
    end else begin
      rvfi0_i = r;
    end
  endtask

  task automatic step_cycle();
    @(posedge clk_i);
    #10;
    rvfi0_i.valid = 1'b0;
    rvfi1_i.valid = 1'b0;
  endtask

  task automatic retire_one(bit h, logic [31:0] raw, logic [31:0] insn,
                            logic [31:0] imm, bit comp);
    drive_retire(h, random_port(), raw, insn, imm, comp);
    step_cycle();
  endtask

  task automatic wait_drained();
    while (exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
      @(negedge clk_i);
    end
    step_cycle();
  endtask

  task automatic test_formats();
    retire_one(0, 32'hFFD10093, 32'hFFD10093, 32'hFFFFFFFD, 0);
    retire_one(0, 32'h00832283, 32'h00832283, 32'h00000008, 0);
    retire_one(0, 32'hFE742E23, 32'hFE742E23, 32'hFFFFFFFC, 0);
    retire_one(0, 32'h00208863, 32'h00208863, 32'h00000010, 0);
    retire_one(0, 32'h123451B7, 32'h123451B7, 32'h12345000, 0);
    retire_one(0, 32'hFF9FF0EF, 32'hFF9FF0EF, 32'hFFFFFFF8, 0);
    retire_one(0, 32'h003100B3, 32'h003100B3, 32'h00000000, 0);
    wait_drained();
  endtask

  task automatic test_compressed();
    retire_one(0, 32'h000010FD, 32'hFFF08093, 32'hFFFFFFFF, 1);
    retire_one(0, 32'h00004115, 32'h00500113, 32'h00000005, 1);
    retire_one(0, 32'h00006185, 32'h000011B7, 32'h00001000, 1);
    retire_one(1, 32'h000040C0, 32'h0044A403, 32'h00000004, 1);
    retire_one(1, 32'h0000C488, 32'h00A4A423, 32'h00000008, 1);
    retire_one(1, 32'h0000A011, 32'h0040006F, 32'h00000004, 1);
    retire_one(1, 32'h0000C401, 32'h00040463, 32'h00000008, 1);
    retire_one(0, 32'h0000808A, 32'h002000B3, 32'h00000000, 1);
    retire_one(0, 32'h0000908A, 32'h002080B3, 32'h00000000, 1);
    // C.SLLI lies outside the subset
    retire_one(0, 32'h00000086, 32'h00000000, 32'h00000000, 1);
    wait_drained();
  endtask

  task automatic test_fp_regs();
    rvfi_t r;
    r = random_port();
    r.frs1_rvalid = 1'b1;
    drive_retire(0, r, 32'h00500093, 32'h00500093, 32'd5, 0);
    step_cycle();
    r = random_port();
    r.frs2_rvalid = 1'b1;
    r.frd_wvalid  = 1'b1;
    drive_retire(1, r, 32'h00500093, 32'h00500093, 32'd5, 0);
    step_cycle();
    r = random_port();
    drive_retire(1, r, 32'h00500093, 32'h00500093, 32'd5, 0);
    step_cycle();
    wait_drained();
  endtask

  task automatic test_mem_kinds();
    rvfi_t r;
    r = random_port();
    r.mem_wmask = 4'hF;
    r.mem_rmask = 4'h3;
    drive_retire(0, r, 32'hFE742E23, 32'hFE742E23, 32'hFFFFFFFC, 0);
    step_cycle();
    r = random_port();
    r.mem_rmask = 4'h1;
    drive_retire(0, r, 32'h00832283, 32'h00832283, 32'd8, 0);
    step_cycle();
    retire_one(0, 32'h00500093, 32'h00500093, 32'd5, 0);
    wait_drained();
  endtask

  // Bursts stay short enough that neither capture queue overflows
  task automatic test_both_harts();
    for (int b = 0; b < 4; b++) begin
      for (int i = 0; i < 3; i++) begin
        drive_retire(0, random_port(), 32'h00500093, 32'h00500093, 32'd5, 0);
        drive_retire(1, random_port(), 32'h123451B7, 32'h123451B7, 32'h12345000, 0);
        step_cycle();
      end
      repeat (4) step_cycle();
    end
    wait_drained();
  endtask

  task automatic test_credit_drop();
    while (owed != 0) begin
      step_cycle();
    end
    subseq_mode  = 1'b1;
    hold         = 1'b1;
    sent_in_hold = 0;
    repeat (20) retire_one(0, 32'h00500093, 32'h00500093, 32'd5, 0);
    if (sent_in_hold > SINK_CREDITS) begin
      $display("More records were sent than the sink had credits for");
      $display(">>> FAIL");
      $fatal(1, "credit overrun");
    end
    hold = 1'b0;
    repeat (10) retire_one(0, 32'h00500093, 32'h00500093, 32'd5, 0);
    wait_drained();
  endtask

  initial begin
    void'($urandom(65827));
    rst_ni       = 1'b0;
    rvfi0_i      = '0;
    rvfi1_i      = '0;
    credit_i     = 1'b0;
    next_pc      = 32'h8000_0000;
    owed         = 0;
    ticks        = 0;
    hold         = 1'b0;
    subseq_mode  = 1'b0;
    gap_seen     = 1'b0;
    sent_in_hold = 0;
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    step_cycle();
    test_formats();
    test_compressed();
    test_fp_regs();
    test_mem_kinds();
    test_both_harts();
    test_credit_drop();
    if (gap_seen) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("No record was dropped while credit was withheld");
      $display(">>> FAIL");
      $fatal(1, "drop path not exercised");
    end
  end

endmodule

/* trace_arbiter.sv */
/*
  Round-robin trace arbiter
  Grants one capture queue per cycle into the shared buffer while it has
  room, rotating priority after every grant, and tags the hart index.
*/
`timescale 1ns/100ps

module trace_arbiter
  import rvfi_trace_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NUM_PORTS-1:0] req_i,
  input  trace_rec_t           rec_i [NUM_PORTS],
  input  logic                 ready_i,
  output logic [NUM_PORTS-1:0] gnt_o,
  output logic                 push_o,
  output trace_rec_t           rec_o
);

  localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  logic [IDX_W-1:0] prio_q;
  logic [IDX_W-1:0] sel;

  // Search starts at the port holding priority
  always_comb begin
    int unsigned idx;
    logic        found;
    gnt_o = '0;
    sel   = prio_q;
    found = 1'b0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      idx = (prio_q + i) % NUM_PORTS;
      if (ready_i && req_i[idx] && !found) begin
        gnt_o[idx] = 1'b1;
        sel        = IDX_W'(idx);
        found      = 1'b1;
      end
    end
  end

  assign push_o = |gnt_o;

  always_comb begin
    rec_o      = rec_i[sel];
    rec_o.hart = sel[0];
  end

  // Winner drops to lowest priority
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else if (push_o) begin
      if (sel == IDX_W'(NUM_PORTS - 1)) begin
        prio_q <= '0;
      end else begin
        prio_q <= sel + 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o));

endmodule

/* trace_buffer.sv */
/*
  Shared trace buffer
  Circular record FIFO in front of the trace sink. A record leaves only
  while the sink has credit, each record costs one credit and the sink
  hands credits back one pulse at a time.
*/
`timescale 1ns/100ps

module trace_buffer
  import rvfi_trace_pkg::*;
#(
  parameter int DEPTH        = 8,
  parameter int SINK_CREDITS = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  trace_rec_t rec_i,
  output logic       ready_o,
  input  logic       credit_i,
  output logic       trace_valid_o,
  output trace_rec_t trace_rec_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(SINK_CREDITS + 1);

  trace_rec_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] credit_q;
  logic             send;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign send    = (count_q != '0) && (credit_q != '0);

  assign trace_valid_o = send;
  assign trace_rec_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push_i, send})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Credit spent and returned in one cycle cancels out
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CRD_W'(SINK_CREDITS);
    end else begin
      unique case ({send, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Sink never returns more than it was given
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CRD_W'(SINK_CREDITS));

  // Without a returned credit an exhausted sink sees nothing next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (credit_q == '0 && !credit_i) |=> !trace_valid_o);

  // The arbiter must respect ready, nothing here checks fullness
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> ready_o);

endmodule
